//--- core_pkg.sv
package core_pkg;

    //////////////////////////////////////////////////
    // Widths and sizes
    //////////////////////////////////////////////////
    localparam int XLEN      = 32;
    localparam int INSTR_W   = 30;
    localparam int ROM_WORDS = 64;

    // Body of addi x0,x0,0, used as the bubble
    localparam logic [INSTR_W-1:0] INSTR_NOP = 30'h0000_0004;

    // Major opcodes, instruction bits 6:2
    localparam logic [4:0] OPC_OP     = 5'b01100;
    localparam logic [4:0] OPC_OPIMM  = 5'b00100;
    localparam logic [4:0] OPC_LUI    = 5'b01101;
    localparam logic [4:0] OPC_JAL    = 5'b11011;
    localparam logic [4:0] OPC_BRANCH = 5'b11000;

    // ALU operations
    localparam logic [2:0] ALU_ADD   = 3'd0;
    localparam logic [2:0] ALU_SUB   = 3'd1;
    localparam logic [2:0] ALU_AND   = 3'd2;
    localparam logic [2:0] ALU_OR    = 3'd3;
    localparam logic [2:0] ALU_XOR   = 3'd4;
    localparam logic [2:0] ALU_PASSB = 3'd5;

    //////////////////////////////////////////////////
    // Instruction body, bits 31:2 of the instruction
    //////////////////////////////////////////////////
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [4:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [4:0]  opcode;
        } i;
    } instr_body_u;

endpackage

//--- rvc_expander.sv
`timescale 1ns/1ps

module rvc_expander (
    input  logic [15:0]           half_i,
    output core_pkg::instr_body_u body_o
);

    logic [4:0]  rd;
    logic [4:0]  rs2;
    logic [11:0] ci_imm;
    logic [11:1] cj_off;

    assign rd  = half_i[11:7];
    assign rs2 = half_i[6:2];

    // CI immediate, sign extended
    assign ci_imm = {{7{half_i[12]}}, half_i[6:2]};

    // CJ offset bits come scrambled in the encoding
    assign cj_off = {half_i[12], half_i[8], half_i[10:9], half_i[6], half_i[7],
                     half_i[2], half_i[11], half_i[5:3]};

    always_comb begin
        body_o = core_pkg::INSTR_NOP;
        case ({half_i[15:13], half_i[1:0]})
            // c.li
            5'b010_01: begin
                body_o = {ci_imm, 5'd0, 3'b000, rd, core_pkg::OPC_OPIMM};
            end
            // c.addi
            5'b000_01: begin
                body_o = {ci_imm, rd, 3'b000, rd, core_pkg::OPC_OPIMM};
            end
            // c.j becomes jal x0
            5'b101_01: begin
                body_o = {cj_off[11], cj_off[10:1], cj_off[11], {8{cj_off[11]}},
                          5'd0, core_pkg::OPC_JAL};
            end
            // c.mv / c.add, rs2 of zero is jr, jalr or ebreak
            5'b100_10: begin
                if (rs2 != 5'd0) begin
                    body_o = {7'd0, rs2, half_i[12] ? rd : 5'd0, 3'b000, rd,
                              core_pkg::OPC_OP};
                end
            end
            default: begin
                body_o = core_pkg::INSTR_NOP;
            end
        endcase
    end

endmodule

//--- instr_fetch.sv
`timescale 1ns/1ps

module instr_fetch (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  stall_i,
    input  logic                  redirect_i,
    input  logic [31:1]           redirect_pc_i,
    output core_pkg::instr_body_u instr_o,
    output logic [31:1]           pc_o,
    output logic                  long_o,
    output logic                  valid_o
);

    logic [core_pkg::XLEN-1:0] rom [core_pkg::ROM_WORDS];

    logic [29:0]               fetch_addr;
    logic                      upper_q;
    logic                      delayed_q;
    logic [15:2]               save_q;

    logic [core_pkg::XLEN-1:0] word;
    logic                      long_lo;
    logic                      long_hi;
    logic [29:0]               addr_next;
    logic [15:0]               half;
    core_pkg::instr_body_u     rvc_body;

    initial begin
        $readmemh("program.hex", rom);
    end

    assign word      = rom[fetch_addr[$clog2(core_pkg::ROM_WORDS)-1:0]];
    assign long_lo   = &word[1:0];
    assign long_hi   = &word[17:16];
    assign addr_next = fetch_addr + 30'd1;
    assign half      = upper_q ? word[31:16] : word[15:0];

    rvc_expander u_rvc (
        .half_i (half),
        .body_o (rvc_body)
    );

    // Upper half of the current word, kept for a straddling instruction
    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            save_q <= word[31:18];
        end
    end

    //////////////////////////////////////////////////
    // Halfword state machine
    //////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            fetch_addr <= '0;
            upper_q    <= 1'b0;
            delayed_q  <= 1'b0;
            instr_o    <= core_pkg::INSTR_NOP;
            valid_o    <= 1'b0;
        end else if (redirect_i) begin
            // Redirect wins over a stall so it is never lost
            fetch_addr <= redirect_pc_i[31:2];
            upper_q    <= redirect_pc_i[1];
            delayed_q  <= 1'b0;
            instr_o    <= core_pkg::INSTR_NOP;
            valid_o    <= 1'b0;
        end else if (stall_i) begin
            instr_o <= core_pkg::INSTR_NOP;
            valid_o <= 1'b0;
        end else if (upper_q) begin
            // Long one here only after a jump into the upper half
            instr_o    <= long_hi ? core_pkg::INSTR_NOP : rvc_body;
            valid_o    <= ~long_hi;
            pc_o       <= {fetch_addr, 1'b1};
            long_o     <= 1'b0;
            fetch_addr <= addr_next;
            upper_q    <= 1'b0;
            delayed_q  <= long_hi;
        end else begin
            if (delayed_q) begin
                // Join saved upper half with the new lower half
                instr_o <= {word[15:0], save_q};
                pc_o    <= {fetch_addr - 30'd1, 1'b1};
                long_o  <= 1'b1;
            end else begin
                instr_o <= long_lo ? word[31:2] : rvc_body;
                pc_o    <= {fetch_addr, 1'b0};
                long_o  <= long_lo;
            end
            valid_o <= 1'b1;
            if (!delayed_q && long_lo) begin
                fetch_addr <= addr_next;
            end else begin
                fetch_addr <= long_hi ? addr_next : fetch_addr;
                upper_q    <= ~long_hi;
                delayed_q  <= long_hi;
            end
        end
    end

endmodule

//--- instr_decode.sv
`timescale 1ns/1ps

module instr_decode (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      flush_i,
    input  core_pkg::instr_body_u     instr_i,
    input  logic [31:1]               pc_i,
    input  logic                      long_i,
    input  logic                      valid_i,
    input  logic [core_pkg::XLEN-1:0] rs1_data_i,
    input  logic [core_pkg::XLEN-1:0] rs2_data_i,
    output logic [4:0]                rs1_addr_o,
    output logic [4:0]                rs2_addr_o,
    output logic                      d_valid_o,
    output logic [31:1]               d_pc_o,
    output logic [4:0]                d_rd_o,
    output logic [4:0]                d_rs1_o,
    output logic [4:0]                d_rs2_o,
    output logic [core_pkg::XLEN-1:0] d_op1_o,
    output logic [core_pkg::XLEN-1:0] d_op2_o,
    output logic [core_pkg::XLEN-1:0] d_imm_o,
    output logic [2:0]                d_alu_op_o,
    output logic                      d_use_imm_o,
    output logic                      d_wen_o,
    output logic                      d_is_branch_o,
    output logic                      d_branch_ne_o,
    output logic                      d_is_jal_o,
    output logic                      d_long_o
);

    logic [2:0]                f3;
    logic [6:0]                f7;
    logic [core_pkg::XLEN-1:0] imm_i;
    logic [core_pkg::XLEN-1:0] imm_u;
    logic [core_pkg::XLEN-1:0] imm_j;
    logic [core_pkg::XLEN-1:0] imm_b;
    logic [core_pkg::XLEN-1:0] imm;
    logic [2:0]                alu_op;
    logic                      use_imm;
    logic                      wen;
    logic                      is_branch;
    logic                      is_jal;

    assign f3         = instr_i.r.funct3;
    assign f7         = instr_i.r.funct7;
    assign rs1_addr_o = instr_i.r.rs1;
    assign rs2_addr_o = instr_i.r.rs2;

    //////////////////////////////////////////////////
    // Immediates
    //////////////////////////////////////////////////
    assign imm_i = {{20{instr_i.i.imm12[11]}}, instr_i.i.imm12};
    assign imm_u = {instr_i.i.imm12, instr_i.i.rs1, instr_i.i.funct3, 12'd0};
    assign imm_j = {{12{instr_i.i.imm12[11]}}, instr_i.i.rs1, instr_i.i.funct3,
                    instr_i.i.imm12[0], instr_i.i.imm12[10:1], 1'b0};
    assign imm_b = {{20{f7[6]}}, instr_i.r.rd[0], f7[5:0], instr_i.r.rd[4:1], 1'b0};

    always_comb begin
        alu_op    = core_pkg::ALU_ADD;
        imm       = imm_i;
        use_imm   = 1'b1;
        wen       = 1'b0;
        is_branch = 1'b0;
        is_jal    = 1'b0;
        case (instr_i.r.opcode)
            core_pkg::OPC_OPIMM: begin
                wen = (f3 == 3'b000);
            end
            core_pkg::OPC_OP: begin
                use_imm = 1'b0;
                wen     = (f7 == 7'h00);
                case (f3)
                    3'b000: begin
                        alu_op = f7[5] ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
                        wen    = (f7 == 7'h00) | (f7 == 7'h20);
                    end
                    3'b100: alu_op = core_pkg::ALU_XOR;
                    3'b110: alu_op = core_pkg::ALU_OR;
                    3'b111: alu_op = core_pkg::ALU_AND;
                    default: wen = 1'b0;
                endcase
            end
            core_pkg::OPC_LUI: begin
                alu_op = core_pkg::ALU_PASSB;
                imm    = imm_u;
                wen    = 1'b1;
            end
            core_pkg::OPC_JAL: begin
                imm    = imm_j;
                is_jal = 1'b1;
                wen    = 1'b1;
            end
            core_pkg::OPC_BRANCH: begin
                imm       = imm_b;
                use_imm   = 1'b0;
                // beq and bne only
                is_branch = (f3[2:1] == 2'b00);
            end
            default: begin
                wen = 1'b0;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // Decode register
    //////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (!rst_i || flush_i || !valid_i) begin
            d_valid_o     <= 1'b0;
            d_wen_o       <= 1'b0;
            d_is_branch_o <= 1'b0;
            d_is_jal_o    <= 1'b0;
        end else begin
            d_valid_o     <= 1'b1;
            d_wen_o       <= wen & (instr_i.r.rd != 5'd0);
            d_is_branch_o <= is_branch;
            d_is_jal_o    <= is_jal;
        end
        d_pc_o        <= pc_i;
        d_rd_o        <= instr_i.r.rd;
        d_rs1_o       <= instr_i.r.rs1;
        d_rs2_o       <= instr_i.r.rs2;
        d_op1_o       <= rs1_data_i;
        d_op2_o       <= rs2_data_i;
        d_imm_o       <= imm;
        d_alu_op_o    <= alu_op;
        d_use_imm_o   <= use_imm;
        d_branch_ne_o <= f3[0];
        d_long_o      <= long_i;
    end

endmodule

//--- alu_execute.sv
`timescale 1ns/1ps

module alu_execute (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      d_valid_i,
    input  logic [31:1]               d_pc_i,
    input  logic [4:0]                d_rd_i,
    input  logic [4:0]                d_rs1_i,
    input  logic [4:0]                d_rs2_i,
    input  logic [core_pkg::XLEN-1:0] d_op1_i,
    input  logic [core_pkg::XLEN-1:0] d_op2_i,
    input  logic [core_pkg::XLEN-1:0] d_imm_i,
    input  logic [2:0]                d_alu_op_i,
    input  logic                      d_use_imm_i,
    input  logic                      d_wen_i,
    input  logic                      d_is_branch_i,
    input  logic                      d_branch_ne_i,
    input  logic                      d_is_jal_i,
    input  logic                      d_long_i,
    output logic                      redirect_o,
    output logic [31:1]               target_o,
    output logic                      valid_o,
    output logic [31:1]               pc_o,
    output logic [4:0]                rd_o,
    output logic                      wen_o,
    output logic [core_pkg::XLEN-1:0] data_o,
    output logic                      long_o
);

    logic [core_pkg::XLEN-1:0] op1;
    logic [core_pkg::XLEN-1:0] op2;
    logic [core_pkg::XLEN-1:0] alu_b;
    logic [core_pkg::XLEN-1:0] alu_res;
    logic [core_pkg::XLEN-1:0] pc_full;
    logic [core_pkg::XLEN-1:0] link;
    logic [core_pkg::XLEN-1:0] target;
    logic                      taken;

    // Bypass from the previous result, still in the output register
    assign op1   = (valid_o && wen_o && rd_o == d_rs1_i) ? data_o : d_op1_i;
    assign op2   = (valid_o && wen_o && rd_o == d_rs2_i) ? data_o : d_op2_i;
    assign alu_b = d_use_imm_i ? d_imm_i : op2;

    always_comb begin
        case (d_alu_op_i)
            core_pkg::ALU_ADD:   alu_res = op1 + alu_b;
            core_pkg::ALU_SUB:   alu_res = op1 - alu_b;
            core_pkg::ALU_AND:   alu_res = op1 & alu_b;
            core_pkg::ALU_OR:    alu_res = op1 | alu_b;
            core_pkg::ALU_XOR:   alu_res = op1 ^ alu_b;
            core_pkg::ALU_PASSB: alu_res = alu_b;
            default:             alu_res = op1 + alu_b;
        endcase
    end

    //////////////////////////////////////////////////
    // Branches and jumps
    //////////////////////////////////////////////////
    assign pc_full = {d_pc_i, 1'b0};
    assign link    = pc_full + (d_long_i ? 32'd4 : 32'd2);
    assign target  = pc_full + d_imm_i;
    assign taken   = d_is_branch_i & ((op1 == op2) ^ d_branch_ne_i);

    assign redirect_o = d_valid_i & (d_is_jal_i | taken);
    assign target_o   = target[31:1];

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            valid_o <= 1'b0;
            wen_o   <= 1'b0;
        end else begin
            valid_o <= d_valid_i;
            wen_o   <= d_valid_i & d_wen_i;
        end
        pc_o   <= d_pc_i;
        rd_o   <= d_rd_i;
        data_o <= d_is_jal_i ? link : alu_res;
        long_o <= d_long_i;
    end

endmodule

//--- reg_result.sv
`timescale 1ns/1ps

module reg_result (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      valid_i,
    input  logic [31:1]               pc_i,
    input  logic [4:0]                rd_i,
    input  logic                      wen_i,
    input  logic [core_pkg::XLEN-1:0] data_i,
    input  logic                      long_i,
    input  logic [4:0]                rs1_addr_i,
    input  logic [4:0]                rs2_addr_i,
    output logic [core_pkg::XLEN-1:0] rs1_data_o,
    output logic [core_pkg::XLEN-1:0] rs2_data_o,
    output logic                      retire_valid_o,
    output logic [31:0]               retire_pc_o,
    output logic [4:0]                retire_rd_o,
    output logic [core_pkg::XLEN-1:0] retire_data_o,
    output logic                      retire_long_o
);

    logic [core_pkg::XLEN-1:0] regs [32];
    logic                      wr;

    assign wr = valid_i & wen_i & (rd_i != 5'd0);

    always_ff @(posedge clk_i) begin
        if (wr) begin
            regs[rd_i] <= data_i;
        end
    end

    // x0 reads zero, a write in the same cycle goes straight through
    assign rs1_data_o = (rs1_addr_i == 5'd0) ? '0 :
                        (wr && rd_i == rs1_addr_i) ? data_i : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == 5'd0) ? '0 :
                        (wr && rd_i == rs2_addr_i) ? data_i : regs[rs2_addr_i];

    //////////////////////////////////////////////////
    // Retire record
    //////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            retire_valid_o <= 1'b0;
        end else begin
            retire_valid_o <= valid_i;
        end
        retire_pc_o   <= {pc_i, 1'b0};
        retire_rd_o   <= wr ? rd_i : 5'd0;
        retire_data_o <= wr ? data_i : '0;
        retire_long_o <= long_i;
    end

endmodule

//--- rv_core.sv
`timescale 1ns/1ps

module rv_core (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      stall_i,
    output logic                      retire_valid_o,
    output logic [31:0]               retire_pc_o,
    output logic [4:0]                retire_rd_o,
    output logic [core_pkg::XLEN-1:0] retire_data_o,
    output logic                      retire_long_o
);

    // Fetch outputs
    core_pkg::instr_body_u     f_instr;
    logic [31:1]               f_pc;
    logic                      f_long;
    logic                      f_valid;

    // Register file ports
    logic [4:0]                rs1_addr;
    logic [4:0]                rs2_addr;
    logic [core_pkg::XLEN-1:0] rs1_data;
    logic [core_pkg::XLEN-1:0] rs2_data;

    // Decode register
    logic                      d_valid;
    logic [31:1]               d_pc;
    logic [4:0]                d_rd;
    logic [4:0]                d_rs1;
    logic [4:0]                d_rs2;
    logic [core_pkg::XLEN-1:0] d_op1;
    logic [core_pkg::XLEN-1:0] d_op2;
    logic [core_pkg::XLEN-1:0] d_imm;
    logic [2:0]                d_alu_op;
    logic                      d_use_imm;
    logic                      d_wen;
    logic                      d_is_branch;
    logic                      d_branch_ne;
    logic                      d_is_jal;
    logic                      d_long;

    // Execute register and redirect
    logic                      ex_redirect;
    logic [31:1]               ex_target;
    logic                      e_valid;
    logic [31:1]               e_pc;
    logic [4:0]                e_rd;
    logic                      e_wen;
    logic [core_pkg::XLEN-1:0] e_data;
    logic                      e_long;

    instr_fetch u_fetch (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .stall_i       (stall_i),
        .redirect_i    (ex_redirect),
        .redirect_pc_i (ex_target),
        .instr_o       (f_instr),
        .pc_o          (f_pc),
        .long_o        (f_long),
        .valid_o       (f_valid)
    );

    instr_decode u_decode (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .flush_i       (ex_redirect),
        .instr_i       (f_instr),
        .pc_i          (f_pc),
        .long_i        (f_long),
        .valid_i       (f_valid),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr),
        .d_valid_o     (d_valid),
        .d_pc_o        (d_pc),
        .d_rd_o        (d_rd),
        .d_rs1_o       (d_rs1),
        .d_rs2_o       (d_rs2),
        .d_op1_o       (d_op1),
        .d_op2_o       (d_op2),
        .d_imm_o       (d_imm),
        .d_alu_op_o    (d_alu_op),
        .d_use_imm_o   (d_use_imm),
        .d_wen_o       (d_wen),
        .d_is_branch_o (d_is_branch),
        .d_branch_ne_o (d_branch_ne),
        .d_is_jal_o    (d_is_jal),
        .d_long_o      (d_long)
    );

    alu_execute u_execute (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .d_valid_i     (d_valid),
        .d_pc_i        (d_pc),
        .d_rd_i        (d_rd),
        .d_rs1_i       (d_rs1),
        .d_rs2_i       (d_rs2),
        .d_op1_i       (d_op1),
        .d_op2_i       (d_op2),
        .d_imm_i       (d_imm),
        .d_alu_op_i    (d_alu_op),
        .d_use_imm_i   (d_use_imm),
        .d_wen_i       (d_wen),
        .d_is_branch_i (d_is_branch),
        .d_branch_ne_i (d_branch_ne),
        .d_is_jal_i    (d_is_jal),
        .d_long_i      (d_long),
        .redirect_o    (ex_redirect),
        .target_o      (ex_target),
        .valid_o       (e_valid),
        .pc_o          (e_pc),
        .rd_o          (e_rd),
        .wen_o         (e_wen),
        .data_o        (e_data),
        .long_o        (e_long)
    );

    reg_result u_result (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .valid_i        (e_valid),
        .pc_i           (e_pc),
        .rd_i           (e_rd),
        .wen_i          (e_wen),
        .data_i         (e_data),
        .long_i         (e_long),
        .rs1_addr_i     (rs1_addr),
        .rs2_addr_i     (rs2_addr),
        .rs1_data_o     (rs1_data),
        .rs2_data_o     (rs2_data),
        .retire_valid_o (retire_valid_o),
        .retire_pc_o    (retire_pc_o),
        .retire_rd_o    (retire_rd_o),
        .retire_data_o  (retire_data_o),
        .retire_long_o  (retire_long_o)
    );

endmodule

//--- tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;

    localparam int RETIRE_TIMEOUT = 200;
    localparam int RESET_TIMEOUT  = 50;

    logic        clk_i;
    logic        rst_i;
    logic        stall_i;
    logic        retire_valid_o;
    logic [31:0] retire_pc_o;
    logic [4:0]  retire_rd_o;
    logic [31:0] retire_data_o;
    logic        retire_long_o;

    int          current_record;

    // Expected retire records in program order
    logic [31:0] exp_pc_q[$];
    logic [4:0]  exp_rd_q[$];
    logic [31:0] exp_data_q[$];
    logic        exp_long_q[$];

    rv_core dut (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .stall_i        (stall_i),
        .retire_valid_o (retire_valid_o),
        .retire_pc_o    (retire_pc_o),
        .retire_rd_o    (retire_rd_o),
        .retire_data_o  (retire_data_o),
        .retire_long_o  (retire_long_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // Fetch stalls about one cycle in four
    function automatic logic random_stall();
        return ($urandom % 32'd4) == 32'd0;
    endfunction

    // Reset low for the first 8 rising edges
    initial begin
        void'($urandom(64095));
        rst_i   <= 1'b0;
        stall_i <= 1'b0;
        repeat (8) begin
            @(posedge clk_i);
            stall_i <= random_stall();
        end
        rst_i <= 1'b1;
        forever begin
            @(posedge clk_i);
            stall_i <= random_stall();
        end
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////
    task stop_on_failure;
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped after the first failure");
    endtask

    task check_value(input string name, input logic [31:0] actual,
                     input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error: %s is 0x%08h, expected 0x%08h (record %0d)",
                     name, actual, expected, current_record);
            stop_on_failure();
        end
    endtask

    task check_in_rom;
        if (retire_pc_o >= core_pkg::ROM_WORDS * 4) begin
            $display("retired pc 0x%08h lies outside the instruction ROM", retire_pc_o);
            stop_on_failure();
        end
    endtask

    task wait_reset_release;
        int cycles;
        cycles = 0;
        while (rst_i !== 1'b1 && cycles < RESET_TIMEOUT) begin
            @(negedge clk_i);
            cycles++;
        end
        if (rst_i !== 1'b1) begin
            $display("reset was never released");
            stop_on_failure();
        end
    endtask

    // Retire outputs are sampled on the falling edge
    task wait_retire(input int idx);
        int cycles;
        cycles = 0;
        @(negedge clk_i);
        while (retire_valid_o !== 1'b1 && cycles < RETIRE_TIMEOUT) begin
            @(negedge clk_i);
            cycles++;
        end
        if (retire_valid_o !== 1'b1) begin
            $display("no instruction retired within %0d cycles while waiting for record %0d",
                     RETIRE_TIMEOUT, idx);
            stop_on_failure();
        end
    endtask

    task add_record(input logic [31:0] pc, input logic [4:0] rd,
                    input logic [31:0] data, input logic is_long);
        exp_pc_q.push_back(pc);
        exp_rd_q.push_back(rd);
        exp_data_q.push_back(data);
        exp_long_q.push_back(is_long);
    endtask

    //////////////////////////////////////////////////
    // Expected retire sequence
    //////////////////////////////////////////////////
    task load_table;
        // Aligned 32-bit ALU ops with back to back dependencies
        add_record(32'h0000_0000, 5'd1,  32'h0000_0005, 1'b1);
        add_record(32'h0000_0004, 5'd2,  32'h0000_0015, 1'b1);
        add_record(32'h0000_0008, 5'd3,  32'h0000_001a, 1'b1);
        add_record(32'h0000_000c, 5'd4,  32'h0000_0015, 1'b1);
        add_record(32'h0000_0010, 5'd5,  32'h1234_5000, 1'b1);
        add_record(32'h0000_0014, 5'd6,  32'h1234_5015, 1'b1);
        add_record(32'h0000_0018, 5'd7,  32'h1234_501f, 1'b1);
        add_record(32'h0000_001c, 5'd8,  32'h1234_5000, 1'b1);
        // Compressed group
        add_record(32'h0000_0020, 5'd9,  32'hffff_fffd, 1'b0);
        add_record(32'h0000_0022, 5'd9,  32'h0000_0004, 1'b0);
        add_record(32'h0000_0024, 5'd10, 32'h0000_0004, 1'b0);
        add_record(32'h0000_0026, 5'd10, 32'h0000_0009, 1'b0);
        // Long ones across word boundaries
        add_record(32'h0000_0028, 5'd11, 32'h0000_0001, 1'b0);
        add_record(32'h0000_002a, 5'd12, 32'h0000_0800, 1'b1);
        add_record(32'h0000_002e, 5'd13, 32'h0000_07e6, 1'b1);
        add_record(32'h0000_0032, 5'd13, 32'h0000_07e0, 1'b0);
        // Branches and jumps where skipped slots never retire
        add_record(32'h0000_0034, 5'd0,  32'h0000_0000, 1'b1);
        add_record(32'h0000_0038, 5'd0,  32'h0000_0000, 1'b1);
        add_record(32'h0000_0040, 5'd0,  32'h0000_0000, 1'b1);
        add_record(32'h0000_0048, 5'd15, 32'h0000_004c, 1'b1);
        add_record(32'h0000_0054, 5'd0,  32'h0000_0000, 1'b0);
        // c.j lands in an upper half on a straddling addi
        add_record(32'h0000_005a, 5'd14, 32'h0000_07f0, 1'b1);
        add_record(32'h0000_005e, 5'd14, 32'h0000_07f4, 1'b0);
        // Final jump to itself
        add_record(32'h0000_0060, 5'd0,  32'h0000_0000, 1'b1);
        add_record(32'h0000_0060, 5'd0,  32'h0000_0000, 1'b1);
    endtask

    initial begin
        int idx;
        current_record = 0;
        load_table();
        wait_reset_release();
        for (idx = 0; idx < exp_pc_q.size(); idx++) begin
            current_record = idx;
            wait_retire(idx);
            check_in_rom();
            check_value("retire_pc_o", retire_pc_o, exp_pc_q[idx]);
            check_value("retire_rd_o", {27'd0, retire_rd_o}, {27'd0, exp_rd_q[idx]});
            check_value("retire_data_o", retire_data_o, exp_data_q[idx]);
            check_value("retire_long_o", {31'd0, retire_long_o}, {31'd0, exp_long_q[idx]});
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- program.hex
// Instruction ROM image, one 32-bit word per line in hex
// Word n sits at byte address 4*n, a 16-bit instruction in bits 15:0 comes first
00500093  // 0x00 addi x1, x0, 5
01008113  // 0x04 addi x2, x1, 0x10
002081b3  // 0x08 add  x3, x1, x2
40118233  // 0x0c sub  x4, x3, x1
123452b7  // 0x10 lui  x5, 0x12345
0042c333  // 0x14 xor  x6, x5, x4
003363b3  // 0x18 or   x7, x6, x3
0053f433  // 0x1c and  x8, x7, x5
049d54f5  // 0x20 c.li x9, -3       0x22 c.addi x9, 7
95068526  // 0x24 c.mv x10, x9      0x26 c.add x10, x1
86134585  // 0x28 c.li x11, 1       0x2a addi x12, x11, 0x7ff (low half)
06b37ff5  // 0x2c addi (high half)  0x2e sub x13, x12, x3 (low half)
16e94036  // 0x30 sub (high half)   0x32 c.addi x13, -6
00b50463  // 0x34 beq  x10, x11, +8 (not taken)
00b51463  // 0x38 bne  x10, x11, +8 (taken)
05500713  // 0x3c addi x14, x0, 0x55 (skipped)
00c60463  // 0x40 beq  x12, x12, +8 (taken)
06600713  // 0x44 addi x14, x0, 0x66 (skipped)
00c007ef  // 0x48 jal  x15, +12
07700713  // 0x4c addi x14, x0, 0x77 (skipped)
08800713  // 0x50 addi x14, x0, 0x88 (skipped)
4725a019  // 0x54 c.j +6            0x56 c.li x14, 9 (skipped)
87134729  // 0x58 c.li x14, 10 (skipped)  0x5a addi x14, x13, 0x10 (low half)
97260106  // 0x5c addi (high half)  0x5e c.add x14, x9
0000006f  // 0x60 jal  x0, 0
00000013  // 0x64 nop

//--- project.f
core_pkg.sv
rvc_expander.sv
instr_fetch.sv
instr_decode.sv
alu_execute.sv
reg_result.sv
rv_core.sv
tb_rv_core.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary -j 0 --Mdir obj_dir
TOP       = tb_rv_core
FILELIST  = project.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir
